/* project.f */
+incdir+hdl
hdl/core_mem_pkg.sv
hdl/miss_queue.sv
hdl/store_buffer.sv
hdl/l2_arbiter_fsm.sv
hdl/core_mem_top.sv
testbench/tb_core_mem.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing
TOP       = tb_core_mem
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_core_mem.sv */
// --------------------
// Testbench for the core memory path
// L2 model, LFSR stimulus, reference model
// and compare tasks
// --------------------

`timescale 1ns/100ps
`include "core_mem_consts.svh"

module tb_core_mem;

	localparam int NUM_CYCLES = 3000;
	localparam int DRAIN_LIMIT = 2000;
	localparam int LINE_BASE = 'h3a0;

	logic clk;
	logic arst_n_i;
	logic imiss_valid_i;
	core_mem_pkg::miss_req_t imiss_i;
	logic dmiss_valid_i;
	core_mem_pkg::miss_req_t dmiss_i;
	logic store_valid_i;
	core_mem_pkg::store_req_t store_i;
	logic [`CORE_STRANDS-1:0] ibusy_o;
	logic [`CORE_STRANDS-1:0] dbusy_o;
	logic [`CORE_STRANDS-1:0] sbusy_o;
	logic pci_valid_o;
	core_mem_pkg::l2_req_t pci_req_o;
	logic pci_ack_i;
	logic cpi_valid_i;
	core_mem_pkg::l2_rsp_t cpi_rsp_i;
	logic [`CORE_STRANDS-1:0] iresume_o;
	logic [`CORE_STRANDS-1:0] dresume_o;
	logic [`CORE_STRANDS-1:0] sync_fail_o;

	// Reference model, index 0 is the instruction queue and 1 the data queue
	logic [`CORE_STRANDS-1:0] m_pend [2];
	logic [`CORE_STRANDS-1:0] m_sent [2];
	logic [`CORE_STRANDS-1:0] m_merged [2];
	logic [`L2_ADDR_WIDTH-1:0] m_addr [2][`CORE_STRANDS];
	int m_acc [2][`CORE_STRANDS];
	logic [`CORE_STRANDS-1:0] s_pend;
	logic [`CORE_STRANDS-1:0] s_sent;
	logic [`CORE_STRANDS-1:0] s_sync;
	logic [`L2_ADDR_WIDTH-1:0] s_addr [`CORE_STRANDS];
	logic [`LINE_BITS-1:0] s_data [`CORE_STRANDS];
	logic [`MASK_BITS-1:0] s_mask [`CORE_STRANDS];
	int s_acc [`CORE_STRANDS];
	// Strand each requester offers, lowest first, held until acked
	logic sel_v [3];
	int sel_s [3];
	int last_ack [3];
	int last_unit;
	logic [`CORE_STRANDS-1:0] exp_iresume;
	logic [`CORE_STRANDS-1:0] exp_dresume;
	logic [`CORE_STRANDS-1:0] exp_sync_fail;
	logic held_valid;
	core_mem_pkg::l2_req_t held_req;
	core_mem_pkg::l2_req_t l2_q [$];
	logic [15:0] lfsr_q;
	int edge_no;
	int ack_wait;
	int mismatch_count;
	int other_count;
	int req_count;
	int merge_count;

	core_mem_top DUT (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.imiss_valid_i(imiss_valid_i),
		.imiss_i(imiss_i),
		.dmiss_valid_i(dmiss_valid_i),
		.dmiss_i(dmiss_i),
		.store_valid_i(store_valid_i),
		.store_i(store_i),
		.ibusy_o(ibusy_o),
		.dbusy_o(dbusy_o),
		.sbusy_o(sbusy_o),
		.pci_valid_o(pci_valid_o),
		.pci_req_o(pci_req_o),
		.pci_ack_i(pci_ack_i),
		.cpi_valid_i(cpi_valid_i),
		.cpi_rsp_i(cpi_rsp_i),
		.iresume_o(iresume_o),
		.dresume_o(dresume_o),
		.sync_fail_o(sync_fail_o)
	);

	always #2 clk = ~clk;

	// x^16 + x^15 + x^13 + x^4 + 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];
			lfsr_q = {lfsr_q[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_req(input string name, input core_mem_pkg::l2_req_t act,
		input core_mem_pkg::l2_req_t exp);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected=%h actual=%h", name, exp, act);
		end
	endtask

	task automatic check_resume(input string name, input logic [`CORE_STRANDS-1:0] act,
		input logic [`CORE_STRANDS-1:0] exp);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected=%h actual=%h", name, exp, act);
		end
	endtask

	task automatic check_busy(input string name, input logic [`CORE_STRANDS-1:0] act,
		input logic [`CORE_STRANDS-1:0] exp);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected=%h actual=%h", name, exp, act);
		end
	endtask

	task automatic check_unit(input string name, input core_mem_pkg::unit_e act,
		input core_mem_pkg::unit_e exp);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected=%h actual=%h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s expected=%h actual=%h", name, exp, act);
		end
	endtask

	// A requester is visible to the arbiter two edges after its entry arrives
	function automatic logic unit_ready(input int u, input int g);
		logic rdy;
		rdy = 1'b0;
		if (last_ack[u] <= g - 2) begin
			for (int s = 0; s < `CORE_STRANDS; s++) begin
				if (u < 2 && m_pend[u][s] && !m_sent[u][s] && !m_merged[u][s]
					&& m_acc[u][s] <= g - 2)
					rdy = 1'b1;
				if (u == 2 && s_pend[s] && !s_sent[s] && s_acc[s] <= g - 2)
					rdy = 1'b1;
			end
		end
		return rdy;
	endfunction

	task automatic check_grant();
		core_mem_pkg::unit_e exp_u;
		logic found;
		int u;
		found = 1'b0;
		exp_u = core_mem_pkg::UNIT_ICACHE;
		for (int k = 1; k <= 3; k++) begin
			u = (last_unit + k) % 3;
			if (!found && unit_ready(u, edge_no)) begin
				found = 1'b1;
				exp_u = core_mem_pkg::unit_e'(u);
			end
		end
		if (!found) begin
			other_count++;
			$display("Grant to unit %0d while no requester had a request waiting",
				pci_req_o.unit);
		end else
			check_unit("grant unit", pci_req_o.unit, exp_u);
		last_unit = int'(pci_req_o.unit);
	endtask

	task automatic check_entry();
		core_mem_pkg::l2_req_t exp;
		logic ok;
		int u;
		int s;
		exp = '0;
		u = int'(pci_req_o.unit);
		s = 0;
		exp.unit = pci_req_o.unit;
		ok = 1'b0;
		if (u < 3) begin
			s = sel_s[u];
			exp.strand = `STRAND_WIDTH'(s);
		end
		if (u < 2) begin
			ok = sel_v[u] && m_pend[u][s] && !m_sent[u][s] && !m_merged[u][s];
			exp.op = core_mem_pkg::OP_LOAD;
			exp.address = m_addr[u][s];
		end else if (u == 2) begin
			ok = sel_v[u] && s_pend[s] && !s_sent[s];
			exp.op = s_sync[s] ? core_mem_pkg::OP_STORE_SYNC : core_mem_pkg::OP_STORE;
			exp.address = s_addr[s];
			exp.data = s_data[s];
			exp.mask = s_mask[s];
		end
		if (!ok) begin
			other_count++;
			$display("L2 request from unit %0d strand %0d has no pending unsent entry",
				u, pci_req_o.strand);
		end else
			check_req("pci_req_o", pci_req_o, exp);
	endtask

	task automatic check_outputs(input logic new_grant);
		check_busy("ibusy_o", ibusy_o, m_pend[0]);
		check_busy("dbusy_o", dbusy_o, m_pend[1]);
		check_busy("sbusy_o", sbusy_o, s_pend);
		check_resume("iresume_o", iresume_o, exp_iresume);
		check_resume("dresume_o", dresume_o, exp_dresume);
		check_resume("sync_fail_o", sync_fail_o, exp_sync_fail);
		if (held_valid) begin
			check_flag("pci_valid_o", pci_valid_o, 1'b1);
			check_req("pci_req_o while held", pci_req_o, held_req);
		end
		if (pci_valid_o) begin
			if (new_grant)
				check_grant();
			check_entry();
		end
	endtask

	task automatic accept_miss(input int u, input core_mem_pkg::miss_req_t m, input int e);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < `CORE_STRANDS; i++) begin
			if (m_pend[u][i] && m_addr[u][i] == m.address)
				hit = 1'b1;
		end
		m_pend[u][m.strand] = 1'b1;
		m_sent[u][m.strand] = 1'b0;
		m_merged[u][m.strand] = hit;
		m_addr[u][m.strand] = m.address;
		m_acc[u][m.strand] = e;
		if (hit)
			merge_count++;
	endtask

	// Applies the coming rising edge to the model
	task automatic predict_edge();
		logic [`CORE_STRANDS-1:0] comp [2];
		logic [`CORE_STRANDS-1:0] pend_pre [2];
		logic [`CORE_STRANDS-1:0] sdone;
		logic [`CORE_STRANDS-1:0] spend_pre;
		logic [`CORE_STRANDS-1:0] cand;
		int e;
		int u;
		int s;
		e = edge_no + 1;
		comp[0] = '0;
		comp[1] = '0;
		sdone = '0;
		exp_sync_fail = '0;
		// Offered strand is released by its ack, else the lowest waiting one
		for (int k = 0; k < 3; k++) begin
			cand = k < 2 ? m_pend[k] & ~m_sent[k] & ~m_merged[k] : s_pend & ~s_sent;
			if (sel_v[k]) begin
				if (pci_valid_o && pci_ack_i && int'(pci_req_o.unit) == k)
					sel_v[k] = 1'b0;
			end else begin
				for (int i = `CORE_STRANDS - 1; i >= 0; i--) begin
					if (cand[i]) begin
						sel_v[k] = 1'b1;
						sel_s[k] = i;
					end
				end
			end
		end
		if (pci_valid_o && pci_ack_i) begin
			u = int'(pci_req_o.unit);
			if (u < 2)
				m_sent[u][pci_req_o.strand] = 1'b1;
			else if (u == 2)
				s_sent[pci_req_o.strand] = 1'b1;
			if (u < 3)
				last_ack[u] = e;
			l2_q.push_back(pci_req_o);
			req_count++;
		end
		if (cpi_valid_i) begin
			u = int'(cpi_rsp_i.unit);
			s = int'(cpi_rsp_i.strand);
			if (u < 2 && cpi_rsp_i.op == core_mem_pkg::RSP_LOAD_DONE) begin
				for (int i = 0; i < `CORE_STRANDS; i++) begin
					if (m_pend[u][i] && (i == s
						|| (m_merged[u][i] && m_addr[u][i] == m_addr[u][s])))
						comp[u][i] = 1'b1;
				end
			end else if (u == 2 && cpi_rsp_i.op == core_mem_pkg::RSP_STORE_DONE) begin
				sdone[s] = s_pend[s];
				exp_sync_fail[s] = s_pend[s] && s_sync[s] && !cpi_rsp_i.status;
			end
		end
		exp_iresume = comp[0];
		exp_dresume = comp[1] | sdone;
		for (int k = 0; k < 2; k++) begin
			pend_pre[k] = m_pend[k];
			m_pend[k] &= ~comp[k];
			m_sent[k] &= ~comp[k];
			m_merged[k] &= ~comp[k];
		end
		spend_pre = s_pend;
		s_pend &= ~sdone;
		s_sent &= ~sdone;
		if (imiss_valid_i && !pend_pre[0][imiss_i.strand])
			accept_miss(0, imiss_i, e);
		if (dmiss_valid_i && !pend_pre[1][dmiss_i.strand])
			accept_miss(1, dmiss_i, e);
		if (store_valid_i && !spend_pre[store_i.strand]) begin
			s_pend[store_i.strand] = 1'b1;
			s_sent[store_i.strand] = 1'b0;
			s_sync[store_i.strand] = store_i.sync;
			s_addr[store_i.strand] = store_i.address;
			s_data[store_i.strand] = store_i.data;
			s_mask[store_i.strand] = store_i.mask;
			s_acc[store_i.strand] = e;
		end
		held_valid = pci_valid_o && !pci_ack_i;
		held_req = pci_req_o;
	endtask

	task automatic drive_inputs(input logic iv, input core_mem_pkg::miss_req_t im,
		input logic dv, input core_mem_pkg::miss_req_t dm, input logic sv,
		input core_mem_pkg::store_req_t st, input logic ack,
		input logic cv, input core_mem_pkg::l2_rsp_t rsp);
		@(posedge clk);
		edge_no++;
		imiss_valid_i <= iv;
		imiss_i <= im;
		dmiss_valid_i <= dv;
		dmiss_i <= dm;
		store_valid_i <= sv;
		store_i <= st;
		pci_ack_i <= ack;
		cpi_valid_i <= cv;
		cpi_rsp_i <= rsp;
	endtask

	task automatic release_reset();
		@(posedge clk);
		arst_n_i <= 1'b1;
	endtask

	task automatic step_cycle(input logic gen);
		core_mem_pkg::l2_rsp_t rsp;
		core_mem_pkg::miss_req_t im;
		core_mem_pkg::miss_req_t dm;
		core_mem_pkg::store_req_t st;
		logic iv;
		logic dv;
		logic sv;
		logic cv;
		logic ack_next;
		int idx;
		@(negedge clk);
		check_outputs(pci_valid_o && !held_valid);
		// L2 side: random ack delay per grant
		ack_next = 1'b0;
		if (pci_valid_o && !pci_ack_i) begin
			if (!held_valid)
				ack_wait = int'(take_bits(3));
			if (ack_wait == 0)
				ack_next = 1'b1;
			else
				ack_wait--;
		end
		predict_edge();
		// Accepted requests are answered in random order
		rsp = '0;
		cv = 1'b0;
		if (l2_q.size() > 0 && take_bits(2) == 0) begin
			idx = int'(take_bits(4)) % l2_q.size();
			rsp.status = 1'(take_bits(1));
			rsp.unit = l2_q[idx].unit;
			rsp.strand = l2_q[idx].strand;
			rsp.way = l2_q[idx].way;
			rsp.op = l2_q[idx].op == core_mem_pkg::OP_LOAD ?
				core_mem_pkg::RSP_LOAD_DONE : core_mem_pkg::RSP_STORE_DONE;
			l2_q.delete(idx);
			cv = 1'b1;
			$display("L2 response unit %0d strand %0d status %0d",
				rsp.unit, rsp.strand, rsp.status);
		end
		im = '0;
		dm = '0;
		st = '0;
		iv = 1'b0;
		dv = 1'b0;
		sv = 1'b0;
		if (gen && take_bits(1) != 0) begin
			im.strand = `STRAND_WIDTH'(take_bits(2));
			im.address = `L2_ADDR_WIDTH'(LINE_BASE + take_bits(2));
			iv = !m_pend[0][im.strand];
		end
		if (gen && take_bits(1) != 0) begin
			dm.strand = `STRAND_WIDTH'(take_bits(2));
			dm.address = `L2_ADDR_WIDTH'(LINE_BASE + take_bits(2));
			dv = !m_pend[1][dm.strand];
		end
		if (gen && take_bits(2) == 0) begin
			st.strand = `STRAND_WIDTH'(take_bits(2));
			st.address = `L2_ADDR_WIDTH'(LINE_BASE + take_bits(2));
			st.sync = 1'(take_bits(1));
			for (int i = 0; i < `LINE_BITS / 32; i++)
				st.data[32*i +: 32] = take_bits(32);
			st.mask = {take_bits(32), take_bits(32)};
			sv = !s_pend[st.strand];
		end
		drive_inputs(iv, im, dv, dm, sv, st, ack_next, cv, rsp);
	endtask

	function automatic logic all_idle();
		return m_pend[0] == '0 && m_pend[1] == '0 && s_pend == '0
			&& l2_q.size() == 0 && !pci_valid_o;
	endfunction

	initial begin
		int t;
		clk = 1'b0;
		arst_n_i = 1'b0;
		imiss_valid_i = 1'b0;
		imiss_i = '0;
		dmiss_valid_i = 1'b0;
		dmiss_i = '0;
		store_valid_i = 1'b0;
		store_i = '0;
		pci_ack_i = 1'b0;
		cpi_valid_i = 1'b0;
		cpi_rsp_i = '0;
		lfsr_q = 16'd57;
		for (int k = 0; k < 2; k++) begin
			m_pend[k] = '0;
			m_sent[k] = '0;
			m_merged[k] = '0;
		end
		s_pend = '0;
		s_sent = '0;
		s_sync = '0;
		for (int k = 0; k < 3; k++) begin
			last_ack[k] = -100;
			sel_v[k] = 1'b0;
			sel_s[k] = 0;
		end
		last_unit = 2;
		exp_iresume = '0;
		exp_dresume = '0;
		exp_sync_fail = '0;
		held_valid = 1'b0;
		held_req = '0;
		edge_no = 0;
		ack_wait = 0;
		mismatch_count = 0;
		other_count = 0;
		req_count = 0;
		merge_count = 0;

		// Outputs stay quiet while in reset
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			check_flag("pci_valid_o", pci_valid_o, 1'b0);
			check_busy("ibusy_o", ibusy_o, '0);
			check_busy("dbusy_o", dbusy_o, '0);
			check_busy("sbusy_o", sbusy_o, '0);
			check_resume("iresume_o", iresume_o, '0);
			check_resume("dresume_o", dresume_o, '0);
			check_resume("sync_fail_o", sync_fail_o, '0);
		end
		release_reset();

		for (int c = 0; c < NUM_CYCLES; c++)
			step_cycle(1'b1);
		for (t = 0; t < DRAIN_LIMIT && !all_idle(); t++)
			step_cycle(1'b0);
		if (!all_idle()) begin
			other_count++;
			$display("Timeout: outstanding L2 requests did not drain in %0d cycles",
				DRAIN_LIMIT);
		end else
			step_cycle(1'b0);

		$display("mismatches %0d, other errors %0d, requests %0d, merges %0d",
			mismatch_count, other_count, req_count, merge_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* hdl/core_mem_top.sv */
// --------------------
// Core memory path: instruction and data miss
// queues, store buffer, L2 port arbiter
// --------------------

`timescale 1ns/100ps
`include "core_mem_consts.svh"

module core_mem_top (
	input logic clk,
	input logic arst_n_i,
	input logic imiss_valid_i,
	input core_mem_pkg::miss_req_t imiss_i,
	input logic dmiss_valid_i,
	input core_mem_pkg::miss_req_t dmiss_i,
	input logic store_valid_i,
	input core_mem_pkg::store_req_t store_i,
	output logic [`CORE_STRANDS-1:0] ibusy_o,
	output logic [`CORE_STRANDS-1:0] dbusy_o,
	output logic [`CORE_STRANDS-1:0] sbusy_o,
	output logic pci_valid_o,
	output core_mem_pkg::l2_req_t pci_req_o,
	input logic pci_ack_i,
	input logic cpi_valid_i,
	input core_mem_pkg::l2_rsp_t cpi_rsp_i,
	output logic [`CORE_STRANDS-1:0] iresume_o,
	output logic [`CORE_STRANDS-1:0] dresume_o,
	output logic [`CORE_STRANDS-1:0] sync_fail_o
);

	logic icache_valid;
	logic dcache_valid;
	logic stbuf_valid;
	core_mem_pkg::l2_req_t icache_req;
	core_mem_pkg::l2_req_t dcache_req;
	core_mem_pkg::l2_req_t stbuf_req;
	logic icache_ack;
	logic dcache_ack;
	logic stbuf_ack;
	logic [`CORE_STRANDS-1:0] dload_complete;
	logic [`CORE_STRANDS-1:0] store_resume;

	miss_queue #(.UNIT(core_mem_pkg::UNIT_ICACHE)) imiss_queue (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.miss_valid_i(imiss_valid_i),
		.miss_i(imiss_i),
		.busy_o(ibusy_o),
		.req_valid_o(icache_valid),
		.req_o(icache_req),
		.req_ack_i(icache_ack),
		.cpi_valid_i(cpi_valid_i),
		.cpi_rsp_i(cpi_rsp_i),
		.load_complete_o(iresume_o)
	);

	miss_queue #(.UNIT(core_mem_pkg::UNIT_DCACHE)) dmiss_queue (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.miss_valid_i(dmiss_valid_i),
		.miss_i(dmiss_i),
		.busy_o(dbusy_o),
		.req_valid_o(dcache_valid),
		.req_o(dcache_req),
		.req_ack_i(dcache_ack),
		.cpi_valid_i(cpi_valid_i),
		.cpi_rsp_i(cpi_rsp_i),
		.load_complete_o(dload_complete)
	);

	store_buffer stbuf (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.store_valid_i(store_valid_i),
		.store_i(store_i),
		.busy_o(sbusy_o),
		.req_valid_o(stbuf_valid),
		.req_o(stbuf_req),
		.req_ack_i(stbuf_ack),
		.cpi_valid_i(cpi_valid_i),
		.cpi_rsp_i(cpi_rsp_i),
		.resume_o(store_resume),
		.sync_fail_o(sync_fail_o)
	);

	l2_arbiter_fsm arbiter (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.icache_valid_i(icache_valid),
		.dcache_valid_i(dcache_valid),
		.stbuf_valid_i(stbuf_valid),
		.icache_req_i(icache_req),
		.dcache_req_i(dcache_req),
		.stbuf_req_i(stbuf_req),
		.pci_ack_i(pci_ack_i),
		.pci_valid_o(pci_valid_o),
		.pci_req_o(pci_req_o),
		.icache_ack_o(icache_ack),
		.dcache_ack_o(dcache_ack),
		.stbuf_ack_o(stbuf_ack)
	);

	// Data-side strands wake on either a load fill or a store completion
	assign dresume_o = dload_complete | store_resume;

endmodule

/* hdl/l2_arbiter_fsm.sv */
// --------------------
// Round-robin grant of the L2 request port
// Holds the winner until the L2 acks
// --------------------

`timescale 1ns/100ps

module l2_arbiter_fsm (
	input logic clk,
	input logic arst_n_i,
	input logic icache_valid_i,
	input logic dcache_valid_i,
	input logic stbuf_valid_i,
	input core_mem_pkg::l2_req_t icache_req_i,
	input core_mem_pkg::l2_req_t dcache_req_i,
	input core_mem_pkg::l2_req_t stbuf_req_i,
	input logic pci_ack_i,
	output logic pci_valid_o,
	output core_mem_pkg::l2_req_t pci_req_o,
	output logic icache_ack_o,
	output logic dcache_ack_o,
	output logic stbuf_ack_o
);

	core_mem_pkg::arb_state_e state_q;
	// Also serves as last winner while idle
	core_mem_pkg::unit_e grant_q;
	core_mem_pkg::unit_e pick;
	logic pick_found;
	logic [2:0] valid_vec;
	logic hold;
	int idx;

	assign valid_vec = {stbuf_valid_i, dcache_valid_i, icache_valid_i};

	// Search starts one past the last winner
	always_comb begin
		pick = grant_q;
		pick_found = 1'b0;
		idx = 0;
		for (int i = 1; i <= 3; i++) begin
			idx = (int'(grant_q) + i) % 3;
			if (!pick_found && valid_vec[idx]) begin
				pick_found = 1'b1;
				pick = core_mem_pkg::unit_e'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= core_mem_pkg::ARB_IDLE;
			grant_q <= core_mem_pkg::UNIT_STBUF;
		end else begin
			case (state_q)
				core_mem_pkg::ARB_IDLE: begin
					if (pick_found) begin
						grant_q <= pick;
						state_q <= core_mem_pkg::ARB_HOLD;
					end
				end
				core_mem_pkg::ARB_HOLD: begin
					if (pci_ack_i)
						state_q <= core_mem_pkg::ARB_IDLE;
				end
				default: state_q <= core_mem_pkg::ARB_IDLE;
			endcase
		end
	end

	assign hold = state_q == core_mem_pkg::ARB_HOLD;
	assign pci_valid_o = hold;

	always_comb begin
		case (grant_q)
			core_mem_pkg::UNIT_ICACHE: pci_req_o = icache_req_i;
			core_mem_pkg::UNIT_DCACHE: pci_req_o = dcache_req_i;
			default: pci_req_o = stbuf_req_i;
		endcase
	end

	assign icache_ack_o = hold && pci_ack_i && grant_q == core_mem_pkg::UNIT_ICACHE;
	assign dcache_ack_o = hold && pci_ack_i && grant_q == core_mem_pkg::UNIT_DCACHE;
	assign stbuf_ack_o = hold && pci_ack_i && grant_q == core_mem_pkg::UNIT_STBUF;

endmodule

/* hdl/store_buffer.sv */
// --------------------
// Pending store per strand
// Issues L2 stores, resumes on the store response
// --------------------

`timescale 1ns/100ps
`include "core_mem_consts.svh"

module store_buffer (
	input logic clk,
	input logic arst_n_i,
	input logic store_valid_i,
	input core_mem_pkg::store_req_t store_i,
	output logic [`CORE_STRANDS-1:0] busy_o,
	output logic req_valid_o,
	output core_mem_pkg::l2_req_t req_o,
	input logic req_ack_i,
	input logic cpi_valid_i,
	input core_mem_pkg::l2_rsp_t cpi_rsp_i,
	output logic [`CORE_STRANDS-1:0] resume_o,
	output logic [`CORE_STRANDS-1:0] sync_fail_o
);

	logic [`CORE_STRANDS-1:0] pending_q;
	logic [`CORE_STRANDS-1:0] issued_q;
	logic [`CORE_STRANDS-1:0] sync_q;
	logic [`L2_ADDR_WIDTH-1:0] addr_q [`CORE_STRANDS];
	logic [`LINE_BITS-1:0] data_q [`CORE_STRANDS];
	logic [`MASK_BITS-1:0] mask_q [`CORE_STRANDS];
	logic sel_valid_q;
	logic [`STRAND_WIDTH-1:0] sel_strand_q;
	logic accept;
	logic [`CORE_STRANDS-1:0] done;
	logic [`CORE_STRANDS-1:0] candidates;
	logic cand_found;
	logic [`STRAND_WIDTH-1:0] cand_strand;

	assign accept = store_valid_i && !pending_q[store_i.strand];

	always_comb begin
		done = '0;
		if (cpi_valid_i && cpi_rsp_i.unit == core_mem_pkg::UNIT_STBUF
			&& cpi_rsp_i.op == core_mem_pkg::RSP_STORE_DONE)
			done[cpi_rsp_i.strand] = pending_q[cpi_rsp_i.strand];
	end

	assign candidates = pending_q & ~issued_q;

	always_comb begin
		cand_found = 1'b0;
		cand_strand = '0;
		for (int i = `CORE_STRANDS - 1; i >= 0; i--) begin
			if (candidates[i]) begin
				cand_found = 1'b1;
				cand_strand = `STRAND_WIDTH'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pending_q <= '0;
			issued_q <= '0;
			sel_valid_q <= 1'b0;
			sel_strand_q <= '0;
			resume_o <= '0;
			sync_fail_o <= '0;
		end else begin
			resume_o <= done;
			// Status 0 on a sync store means the sync failed
			sync_fail_o <= done & sync_q & {`CORE_STRANDS{~cpi_rsp_i.status}};
			pending_q <= pending_q & ~done;
			issued_q <= issued_q & ~done;
			if (accept) begin
				pending_q[store_i.strand] <= 1'b1;
				issued_q[store_i.strand] <= 1'b0;
			end
			if (sel_valid_q) begin
				if (req_ack_i) begin
					sel_valid_q <= 1'b0;
					issued_q[sel_strand_q] <= 1'b1;
				end
			end else if (cand_found) begin
				sel_valid_q <= 1'b1;
				sel_strand_q <= cand_strand;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q[store_i.strand] <= store_i.address;
			data_q[store_i.strand] <= store_i.data;
			mask_q[store_i.strand] <= store_i.mask;
			sync_q[store_i.strand] <= store_i.sync;
		end
	end

	assign busy_o = pending_q;
	assign req_valid_o = sel_valid_q;

	always_comb begin
		req_o = '0;
		req_o.strand = sel_strand_q;
		req_o.unit = core_mem_pkg::UNIT_STBUF;
		req_o.op = sync_q[sel_strand_q] ? core_mem_pkg::OP_STORE_SYNC : core_mem_pkg::OP_STORE;
		req_o.address = addr_q[sel_strand_q];
		req_o.data = data_q[sel_strand_q];
		req_o.mask = mask_q[sel_strand_q];
	end

endmodule

/* hdl/miss_queue.sv */
// --------------------
// Load miss tracker, one entry per strand
// Merges misses to a line already in flight
// --------------------

`timescale 1ns/100ps
`include "core_mem_consts.svh"

module miss_queue #(
	parameter core_mem_pkg::unit_e UNIT = core_mem_pkg::UNIT_ICACHE
) (
	input logic clk,
	input logic arst_n_i,
	input logic miss_valid_i,
	input core_mem_pkg::miss_req_t miss_i,
	output logic [`CORE_STRANDS-1:0] busy_o,
	output logic req_valid_o,
	output core_mem_pkg::l2_req_t req_o,
	input logic req_ack_i,
	input logic cpi_valid_i,
	input core_mem_pkg::l2_rsp_t cpi_rsp_i,
	output logic [`CORE_STRANDS-1:0] load_complete_o
);

	logic [`CORE_STRANDS-1:0] pending_q;
	logic [`CORE_STRANDS-1:0] issued_q;
	logic [`CORE_STRANDS-1:0] merged_q;
	logic [`L2_ADDR_WIDTH-1:0] addr_q [`CORE_STRANDS];
	logic sel_valid_q;
	logic [`STRAND_WIDTH-1:0] sel_strand_q;
	logic rsp_hit;
	logic accept;
	logic [`CORE_STRANDS-1:0] complete;
	logic [`CORE_STRANDS-1:0] line_match;
	logic [`CORE_STRANDS-1:0] candidates;
	logic cand_found;
	logic [`STRAND_WIDTH-1:0] cand_strand;

	assign rsp_hit = cpi_valid_i && cpi_rsp_i.unit == UNIT
		&& cpi_rsp_i.op == core_mem_pkg::RSP_LOAD_DONE;
	assign accept = miss_valid_i && !pending_q[miss_i.strand];

	// Owner plus everything merged onto its line
	always_comb begin
		complete = '0;
		if (rsp_hit && pending_q[cpi_rsp_i.strand]) begin
			for (int i = 0; i < `CORE_STRANDS; i++) begin
				if (pending_q[i] && (i == int'(cpi_rsp_i.strand)
					|| (merged_q[i] && addr_q[i] == addr_q[cpi_rsp_i.strand])))
					complete[i] = 1'b1;
			end
		end
	end

	// A line finishing this cycle cannot take new merges
	always_comb begin
		line_match = '0;
		for (int i = 0; i < `CORE_STRANDS; i++)
			line_match[i] = pending_q[i] && !complete[i] && addr_q[i] == miss_i.address;
	end

	assign candidates = pending_q & ~issued_q & ~merged_q;

	// Lowest strand wins
	always_comb begin
		cand_found = 1'b0;
		cand_strand = '0;
		for (int i = `CORE_STRANDS - 1; i >= 0; i--) begin
			if (candidates[i]) begin
				cand_found = 1'b1;
				cand_strand = `STRAND_WIDTH'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pending_q <= '0;
			issued_q <= '0;
			merged_q <= '0;
			sel_valid_q <= 1'b0;
			sel_strand_q <= '0;
			load_complete_o <= '0;
		end else begin
			load_complete_o <= complete;
			pending_q <= pending_q & ~complete;
			issued_q <= issued_q & ~complete;
			merged_q <= merged_q & ~complete;
			if (accept) begin
				pending_q[miss_i.strand] <= 1'b1;
				issued_q[miss_i.strand] <= 1'b0;
				merged_q[miss_i.strand] <= |line_match;
			end
			// Selection stays locked until the L2 takes it
			if (sel_valid_q) begin
				if (req_ack_i) begin
					sel_valid_q <= 1'b0;
					issued_q[sel_strand_q] <= 1'b1;
				end
			end else if (cand_found) begin
				sel_valid_q <= 1'b1;
				sel_strand_q <= cand_strand;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			addr_q[miss_i.strand] <= miss_i.address;
	end

	assign busy_o = pending_q;
	assign req_valid_o = sel_valid_q;

	always_comb begin
		req_o = '0;
		req_o.strand = sel_strand_q;
		req_o.unit = UNIT;
		req_o.op = core_mem_pkg::OP_LOAD;
		req_o.address = addr_q[sel_strand_q];
	end

endmodule

/* hdl/core_mem_pkg.sv */
// --------------------
// Types for the L2 request and response ports
// Units, opcodes, arbiter states, strand requests
// --------------------

`include "core_mem_consts.svh"

package core_mem_pkg;

	typedef enum logic [1:0] {
		UNIT_ICACHE = 2'd0,
		UNIT_DCACHE = 2'd1,
		UNIT_STBUF = 2'd2
	} unit_e;

	typedef enum logic [2:0] {
		OP_LOAD = 3'd0,
		OP_STORE = 3'd1,
		OP_STORE_SYNC = 3'd2
	} l2_op_e;

	typedef enum logic [1:0] {
		RSP_LOAD_DONE = 2'd0,
		RSP_STORE_DONE = 2'd1
	} rsp_op_e;

	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_HOLD = 1'b1
	} arb_state_e;

	typedef struct packed {
		logic [`STRAND_WIDTH-1:0] strand;
		unit_e unit;
		l2_op_e op;
		logic [1:0] way;
		logic [`L2_ADDR_WIDTH-1:0] address;
		logic [`LINE_BITS-1:0] data;
		logic [`MASK_BITS-1:0] mask;
	} l2_req_t;

	typedef struct packed {
		logic status;
		unit_e unit;
		logic [`STRAND_WIDTH-1:0] strand;
		rsp_op_e op;
		logic update;
		logic [1:0] way;
		logic [`LINE_BITS-1:0] data;
	} l2_rsp_t;

	typedef struct packed {
		logic [`STRAND_WIDTH-1:0] strand;
		logic [`L2_ADDR_WIDTH-1:0] address;
	} miss_req_t;

	typedef struct packed {
		logic [`STRAND_WIDTH-1:0] strand;
		logic [`L2_ADDR_WIDTH-1:0] address;
		logic sync;
		logic [`LINE_BITS-1:0] data;
		logic [`MASK_BITS-1:0] mask;
	} store_req_t;

endpackage

/* hdl/core_mem_consts.svh */
// --------------------
// Strand count and L2 port widths
// for the core memory path
// --------------------

`ifndef CORE_MEM_CONSTS_SVH
`define CORE_MEM_CONSTS_SVH

// Hardware strands per core
`define CORE_STRANDS 4
`define STRAND_WIDTH 2

// Line address and payload widths on the L2 ports
`define L2_ADDR_WIDTH 26
`define LINE_BITS 512
`define MASK_BITS 64

`endif
